// File: design/tag_pkg.sv
package tag_pkg;

   // ************************************************************
   // shared types for the serial configuration network
   // ************************************************************

   // width of the master state register
   localparam int tag_state_width_gp = 2;

   // one transfer from master to client
   //   op 1            param is a data bit
   //   op 0, param 1   clear the client
   //   op 0, param 0   idle
   typedef struct packed
   {
      logic op;
      logic param;
   } tag_bit_s;

   // master FSM
   // idle waits for the start bit
   // header shifts in length, data_not_reset and node id
   // transfer forwards one payload bit per cycle
   typedef enum logic [tag_state_width_gp-1:0]
   {
      idle     = 2'd0,
      header   = 2'd1,
      transfer = 2'd2
   } tag_state_e;

endpackage

// File: design/tag_bit_rx.sv
`timescale 1ns/1ns

module tag_bit_rx
#(
   parameter int els_p      = 16,
   parameter int lg_width_p = 4
)
(
   input  logic clk_i,
   input  logic reset_i,
   input  logic data_i,
   output logic bit_o,
   output logic link_reset_o
);

   // ************************************************************
   // packet size and zero-run threshold
   // ************************************************************

   // node id bits, length bits and the data_not_reset flag
   localparam int id_width_lp   = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int hdr_bits_lp   = lg_width_p + 1 + id_width_lp;
   localparam int max_len_lp    = (1 << lg_width_p) - 1;
   // start bit + header + longest payload
   localparam int max_packet_lp = 1 + hdr_bits_lp + max_len_lp;
   // threshold is the next power of two at or above the packet
   localparam int lg_reset_lp   = $clog2(max_packet_lp);
   // one extra bit so the threshold shows up as a carry
   localparam int ctr_width_lp  = lg_reset_lp + 1;

   typedef logic [ctr_width_lp-1:0] zero_ctr_t;

   logic      bit_r;
   zero_ctr_t zeros_r;
   logic      carry;

   // pin flop
   always_ff @(posedge clk_i)
   begin
      bit_r <= data_i;
   end

   assign carry = zeros_r[ctr_width_lp-1];

   // ************************************************************
   // zero-run counter
   // ************************************************************

   // a 1 on the line breaks the run
   // carry clears itself so a longer run pulses again
   always_ff @(posedge clk_i)
   begin
      if (reset_i || bit_r || carry)
      begin
         zeros_r <= '0;
      end
      else
      begin
         zeros_r <= zeros_r + zero_ctr_t'(1);
      end
   end

   assign bit_o        = bit_r;
   assign link_reset_o = carry;

endmodule

// File: design/tag_master.sv
`timescale 1ns/1ns

module tag_master
#(
   parameter int els_p       = 16,
   parameter int local_els_p = 4,
   parameter int lg_width_p  = 4,
   // derived, not meant to be overridden
   parameter int id_width_lp = (els_p > 1) ? $clog2(els_p) : 1
)
(
   input  logic                                clk_i,
   input  logic                                reset_i,
   input  logic                                bit_i,
   input  logic                                link_reset_i,
   input  logic [id_width_lp-1:0]              node_id_offset_i,
   output tag_pkg::tag_bit_s [local_els_p-1:0] clients_o
);

   // ************************************************************
   // header layout
   // ************************************************************

   // length arrives first, so it sits in the low bits
   localparam int hdr_bits_lp  = lg_width_p + 1 + id_width_lp;
   localparam int ptr_width_lp = $clog2(hdr_bits_lp + 1);

   typedef logic [id_width_lp-1:0]  node_id_t;
   typedef logic [lg_width_p-1:0]   len_t;
   typedef logic [ptr_width_lp-1:0] hdr_ptr_t;

   typedef struct packed
   {
      node_id_t node_id;
      logic     data_not_reset;
      len_t     len;
   } hdr_s;

   tag_pkg::tag_state_e state_r;
   tag_pkg::tag_state_e state_n;
   hdr_ptr_t            hdr_ptr_r;
   hdr_ptr_t            hdr_ptr_n;
   hdr_s                hdr_r;
   hdr_s                hdr_n;
   tag_pkg::tag_bit_s   tag_n;

   logic     fsm_reset;
   node_id_t local_id;
   logic     above_offset;
   logic     below_limit;
   logic     id_match;

   // link reset only counts while the line is low
   assign fsm_reset = reset_i || (link_reset_i && !bit_i);

   // ************************************************************
   // state and header registers
   // ************************************************************

   always_ff @(posedge clk_i)
   begin
      if (fsm_reset)
      begin
         state_r   <= tag_pkg::idle;
         hdr_ptr_r <= '0;
      end
      else
      begin
         state_r   <= state_n;
         hdr_ptr_r <= hdr_ptr_n;
      end
   end

   // header shift register
   always_ff @(posedge clk_i)
   begin
      hdr_r <= hdr_n;
   end

   // ************************************************************
   // next state
   // ************************************************************

   always_comb
   begin
      state_n     = state_r;
      hdr_ptr_n   = hdr_ptr_r;
      hdr_n       = hdr_r;
      tag_n.op    = 1'b0;
      tag_n.param = 1'b0;

      case (state_r)
         tag_pkg::idle:
         begin
            // first 1 starts a packet, not part of the header
            if (bit_i)
            begin
               state_n = tag_pkg::header;
            end
            hdr_ptr_n = '0;
            hdr_n     = '0;
         end
         tag_pkg::header:
         begin
            // shift in from the top, lsb of length ends at bit 0
            hdr_n     = {bit_i, hdr_r[hdr_bits_lp-1:1]};
            hdr_ptr_n = hdr_ptr_r + hdr_ptr_t'(1);
            // last header bit
            if (hdr_ptr_r == hdr_ptr_t'(hdr_bits_lp - 1))
            begin
               // null packet goes straight back
               if (hdr_n.len == '0)
               begin
                  state_n = tag_pkg::idle;
               end
               else
               begin
                  state_n = tag_pkg::transfer;
               end
            end
         end
         tag_pkg::transfer:
         begin
            // op selects data or clear, param is the line
            tag_n.op    = hdr_r.data_not_reset;
            tag_n.param = bit_i;
            if (hdr_r.len == len_t'(1))
            begin
               state_n = tag_pkg::idle;
            end
            hdr_n.len = hdr_r.len - len_t'(1);
         end
         default:
         begin
            state_n = tag_pkg::idle;
         end
      endcase
   end

   // ************************************************************
   // node window and client demux
   // ************************************************************

   // wraps below the offset, caught by above_offset
   assign local_id     = hdr_r.node_id - node_id_offset_i;
   assign above_offset = (hdr_r.node_id >= node_id_offset_i);
   assign below_limit  = (local_id < local_els_p);
   assign id_match     = above_offset && below_limit;

   // combinational outputs, idle outside transfer
   for (genvar i = 0; i < local_els_p; i++)
   begin : g_demux
      assign clients_o[i] = (id_match && (local_id == node_id_t'(i))) ? tag_n : '0;
   end

endmodule

// File: design/tag_client.sv
`timescale 1ns/1ns

module tag_client
#(
   parameter int client_width_p = 8
)
(
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  tag_pkg::tag_bit_s         tag_i,
   output logic [client_width_p-1:0] data_o,
   output logic                      new_o
);

   // counts 0 .. client_width_p-1
   localparam int cnt_width_lp = $clog2(client_width_p + 1);

   typedef logic [client_width_p-1:0] word_t;
   typedef logic [cnt_width_lp-1:0]   bit_cnt_t;

   word_t    shift_r;
   word_t    shift_n;
   bit_cnt_t count_r;
   word_t    data_r;
   logic     new_r;
   logic     word_done;

   // new bit enters at the top, first bit ends as lsb
   assign shift_n   = {tag_i.param, shift_r[client_width_p-1:1]};
   assign word_done = (count_r == bit_cnt_t'(client_width_p - 1));

   // ************************************************************
   // shift register, word and pulse
   // ************************************************************

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         count_r <= '0;
         data_r  <= '0;
         new_r   <= 1'b0;
      end
      else
      begin
         new_r <= 1'b0;
         if (tag_i.op)
         begin
            shift_r <= shift_n;
            if (word_done)
            begin
               // full word, publish and restart
               data_r  <= shift_n;
               new_r   <= 1'b1;
               count_r <= '0;
            end
            else
            begin
               count_r <= count_r + bit_cnt_t'(1);
            end
         end
         else if (tag_i.param)
         begin
            // clear request, no pulse
            shift_r <= '0;
            count_r <= '0;
            data_r  <= '0;
         end
      end
   end

   assign data_o = data_r;
   assign new_o  = new_r;

endmodule

// File: design/tag_subsystem.sv
`timescale 1ns/1ns

module tag_subsystem
#(
   parameter int els_p          = 16,
   parameter int local_els_p    = 4,
   parameter int lg_width_p     = 4,
   parameter int client_width_p = 8,
   // derived, not meant to be overridden
   parameter int id_width_lp    = (els_p > 1) ? $clog2(els_p) : 1
)
(
   input  logic                                         clk_i,
   input  logic                                         reset_i,
   input  logic                                         data_i,
   input  logic [id_width_lp-1:0]                       node_id_offset_i,
   output logic [local_els_p-1:0][client_width_p-1:0]   client_data_o,
   output logic [local_els_p-1:0]                       client_new_o
);

   logic                                bit_r;
   logic                                link_reset;
   tag_pkg::tag_bit_s [local_els_p-1:0] clients;

   // ************************************************************
   // pin side
   // ************************************************************

   tag_bit_rx #(
      .els_p      (els_p),
      .lg_width_p (lg_width_p)
   ) u_rx (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .data_i       (data_i),
      .bit_o        (bit_r),
      .link_reset_o (link_reset)
   );

   // header parse and demux
   tag_master #(
      .els_p       (els_p),
      .local_els_p (local_els_p),
      .lg_width_p  (lg_width_p)
   ) u_master (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .bit_i            (bit_r),
      .link_reset_i     (link_reset),
      .node_id_offset_i (node_id_offset_i),
      .clients_o        (clients)
   );

   // ************************************************************
   // client row
   // ************************************************************

   for (genvar i = 0; i < local_els_p; i++)
   begin : g_client
      tag_client #(
         .client_width_p (client_width_p)
      ) u_client (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .tag_i   (clients[i]),
         .data_o  (client_data_o[i]),
         .new_o   (client_new_o[i])
      );
   end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
#(
   parameter int period_p       = 10,
   parameter int reset_cycles_p = 4
)
(
   output logic clk_o,
   output logic reset_o
);

   // free running clock
   initial
   begin
      clk_o = 1'b0;
      forever #(period_p / 2) clk_o = ~clk_o;
   end

   // released on a falling edge, same as the data pin
   initial
   begin
      reset_o = 1'b1;
      repeat (reset_cycles_p) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;
   end

endmodule

// File: testbench/tag_subsystem_tb.sv
`timescale 1ns/1ns

module tag_subsystem_tb;

   // ************************************************************
   // sizes, matching the DUT defaults
   // ************************************************************

   localparam int els_lp          = 16;
   localparam int local_els_lp    = 4;
   localparam int lg_width_lp     = 4;
   localparam int client_width_lp = 8;
   localparam int id_width_lp     = $clog2(els_lp);
   localparam int slot_width_lp   = $clog2(local_els_lp);
   localparam int max_len_lp      = (1 << lg_width_lp) - 1;
   // start bit, length, flag, node id, longest payload
   localparam int max_packet_lp   = 1 + lg_width_lp + 1 + id_width_lp + max_len_lp;
   localparam int reset_zeros_lp  = 1 << $clog2(max_packet_lp);
   // upper bound of driven bits: five zero runs, 17 directed and 30 random packets
   localparam int zero_runs_lp    = 5;
   localparam int packets_lp      = 17 + 30;
   localparam int stim_bits_lp    = zero_runs_lp * 2 * reset_zeros_lp
                                    + packets_lp * max_packet_lp;
   localparam int cycle_limit_lp  = stim_bits_lp * 3 / 2 + 200;

   typedef logic [client_width_lp-1:0] word_t;
   typedef logic [id_width_lp-1:0]     node_t;
   typedef logic [lg_width_lp-1:0]     len_t;
   typedef logic [max_len_lp-1:0]      payload_t;

   // what one pin bit does to the model
   typedef struct packed
   {
      logic                     valid;
      logic [slot_width_lp-1:0] slot;
      tag_pkg::tag_bit_s        tag;
   } action_s;

   logic                       clk;
   logic                       reset;
   logic                       data;
   node_t                      offset;
   word_t [local_els_lp-1:0]   client_data;
   logic  [local_els_lp-1:0]   client_new;

   // action of the bit on the pin, then of the bit in the pin flop
   action_s                    act_drv;
   action_s                    act_pin;
   // reference state per client
   word_t [local_els_lp-1:0]   exp_data;
   word_t [local_els_lp-1:0]   exp_shift;
   logic  [local_els_lp-1:0]   exp_new;
   int                         exp_count [local_els_lp];

   int data_errors;
   int pulse_errors;
   int count_errors;
   int pulses_expected;
   int pulses_seen;
   int cycles;

   tb_clock_gen #(
      .period_p       (10),
      .reset_cycles_p (4)
   ) u_clock (
      .clk_o   (clk),
      .reset_o (reset)
   );

   tag_subsystem u_dut (
      .clk_i            (clk),
      .reset_i          (reset),
      .data_i           (data),
      .node_id_offset_i (offset),
      .client_data_o    (client_data),
      .client_new_o     (client_new)
   );

   // ************************************************************
   // reference model
   // ************************************************************

   // data bit lands at index count, so the first bit is the lsb
   task automatic apply_action(input action_s act);
      int s;
      s = act.slot;
      if (act.tag.op)
      begin
         exp_shift[s][exp_count[s]] = act.tag.param;
         exp_count[s]++;
         if (exp_count[s] == client_width_lp)
         begin
            exp_data[s]  = exp_shift[s];
            exp_new[s]   = 1'b1;
            exp_count[s] = 0;
            pulses_expected++;
         end
      end
      else if (act.tag.param)
      begin
         exp_shift[s] = '0;
         exp_data[s]  = '0;
         exp_count[s] = 0;
      end
   endtask

   // pin flop, then client update one edge later
   always @(posedge clk)
   begin
      if (reset)
      begin
         act_pin   = '0;
         exp_data  = '0;
         exp_shift = '0;
         exp_new   = '0;
         for (int i = 0; i < local_els_lp; i++)
         begin
            exp_count[i] = 0;
         end
      end
      else
      begin
         exp_new = '0;
         if (act_pin.valid)
         begin
            apply_action(act_pin);
         end
         act_pin = act_drv;
         pulses_seen += $countones(client_new);
      end
   end

   // ************************************************************
   // output checks
   // ************************************************************

   for (genvar i = 0; i < local_els_lp; i++)
   begin : g_check
      // word carried by a pulse
      assert property (@(posedge clk) disable iff (reset)
         client_new[i] |-> (client_data[i] == exp_data[i]))
      else
      begin
         data_errors++;
         $display("** Error: %0t ns client_data_o[%0d] on pulse expected %h actual %h",
                  $time, i, $sampled(exp_data[i]), $sampled(client_data[i]));
      end

      // pulse only when a word completes
      assert property (@(posedge clk) disable iff (reset)
         client_new[i] == exp_new[i])
      else
      begin
         pulse_errors++;
         $display("** Error: %0t ns client_new_o[%0d] expected %b actual %b",
                  $time, i, $sampled(exp_new[i]), $sampled(client_new[i]));
      end

      // word holds between pulses
      assert property (@(posedge clk) disable iff (reset)
         !exp_new[i] |-> (client_data[i] == exp_data[i]))
      else
      begin
         data_errors++;
         $display("** Error: %0t ns client_data_o[%0d] expected %h actual %h",
                  $time, i, $sampled(exp_data[i]), $sampled(client_data[i]));
      end
   end

   // watchdog
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit_lp)
      begin
         $display("timeout: stimulus still running after %0d cycles", cycles);
         $display("errors: data %0d, pulse %0d, count %0d",
                  data_errors, pulse_errors, count_errors);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ************************************************************
   // stimulus
   // ************************************************************

   task automatic drive_bit(input logic b, input action_s act);
      @(negedge clk);
      data    = b;
      act_drv = act;
   endtask

   // start bit, length lsb first, flag, node id lsb first, payload
   task automatic send_packet(input len_t len, input logic dnr, input node_t node,
                              input payload_t payload);
      action_s act;
      int      rel;
      rel       = int'(node) - int'(offset);
      act.valid = (rel >= 0) && (rel < local_els_lp);
      act.slot  = rel[slot_width_lp-1:0];
      act.tag   = '0;
      drive_bit(1'b1, '0);
      for (int k = 0; k < lg_width_lp; k++)
      begin
         drive_bit(len[k], '0);
      end
      drive_bit(dnr, '0);
      for (int k = 0; k < id_width_lp; k++)
      begin
         drive_bit(node[k], '0);
      end
      for (int k = 0; k < int'(len); k++)
      begin
         act.tag.op    = dnr;
         act.tag.param = payload[k];
         drive_bit(payload[k], act);
      end
   endtask

   // start bit and the low length bits only
   task automatic send_cut_header(input int nbits);
      drive_bit(1'b1, '0);
      for (int k = 0; k < nbits; k++)
      begin
         drive_bit(1'b1, '0);
      end
   endtask

   // two link resets worth of zeros
   task automatic long_zeros();
      for (int k = 0; k < 2 * reset_zeros_lp; k++)
      begin
         drive_bit(1'b0, '0);
      end
   endtask

   // only while the line is quiet, the master reads it combinationally
   task automatic set_offset(input node_t value);
      @(negedge clk);
      offset = value;
   endtask

   initial
   begin
      node_t    node;
      len_t     len;
      payload_t payload;

      void'($urandom(2));
      data            = 1'b0;
      offset          = '0;
      act_drv         = '0;
      data_errors     = 0;
      pulse_errors    = 0;
      count_errors    = 0;
      pulses_expected = 0;
      pulses_seen     = 0;
      cycles          = 0;
      wait (reset === 1'b0);

      // quiet line after reset
      long_zeros();

      // single word, then 16 bits as 10 + 6 since length tops out at 15
      send_packet(len_t'(8), 1'b1, node_t'(1), payload_t'('h5a));
      send_packet(len_t'(10), 1'b1, node_t'(3), payload_t'('h2c7));
      send_packet(len_t'(6), 1'b1, node_t'(3), payload_t'('h2b));

      // out of window at offset 0
      send_packet(len_t'(8), 1'b1, node_t'(4), payload_t'('hff));
      send_packet(len_t'(8), 1'b1, node_t'(9), payload_t'('h81));
      long_zeros();

      // offset 5, below, at the limit, far above, then inside
      set_offset(node_t'(5));
      send_packet(len_t'(8), 1'b1, node_t'(3), payload_t'('h11));
      send_packet(len_t'(8), 1'b1, node_t'(9), payload_t'('h22));
      send_packet(len_t'(8), 1'b1, node_t'(15), payload_t'('h33));
      send_packet(len_t'(8), 1'b1, node_t'(6), payload_t'('he4));

      // clear drops both the word and a partial count
      send_packet(len_t'(8), 1'b1, node_t'(7), payload_t'('h3c));
      send_packet(len_t'(3), 1'b1, node_t'(7), payload_t'('h5));
      send_packet(len_t'(4), 1'b0, node_t'(7), payload_t'('hf));
      send_packet(len_t'(8), 1'b1, node_t'(7), payload_t'('h96));

      // null packet, then a header cut by a zero run
      send_packet(len_t'(0), 1'b1, node_t'(8), payload_t'('h0));
      send_packet(len_t'(8), 1'b1, node_t'(8), payload_t'('hc3));
      send_cut_header(2);
      long_zeros();
      send_packet(len_t'(8), 1'b1, node_t'(8), payload_t'('h7e));
      long_zeros();

      // back to back random traffic, about one in six is a clear
      for (int n = 0; n < 30; n++)
      begin
         node    = node_t'($urandom_range(els_lp - 1, 0));
         len     = len_t'($urandom_range(max_len_lp, 1));
         payload = payload_t'($urandom);
         if ($urandom_range(5, 0) == 0)
         begin
            send_packet(len, 1'b0, node, '1);
         end
         else
         begin
            send_packet(len, 1'b1, node, payload);
         end
      end
      long_zeros();

      if (pulses_seen != pulses_expected)
      begin
         count_errors++;
         $display("** Error: %0t ns client_new_o pulse count expected %0d actual %0d",
                  $time, pulses_expected, pulses_seen);
      end
      $display("errors: data %0d, pulse %0d, count %0d",
               data_errors, pulse_errors, count_errors);
      if (data_errors + pulse_errors + count_errors == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: tag_subsystem.f
design/tag_pkg.sv
design/tag_bit_rx.sv
design/tag_master.sv
design/tag_client.sv
design/tag_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tag_subsystem_tb.sv
